// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = imgproc_tb
FILELIST = imgproc.f
BUILD    = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: design/ctrl_regs.sv
module ctrl_regs (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                s_chipselect,
	input  logic                s_read,
	input  logic                s_write,
	input  logic [2:0]          s_address,
	input  logic [31:0]         s_writedata,
	output logic [31:0]         s_readdata,
	output imgproc_pkg::pixel_t box_col
);
	import imgproc_pkg::*;

	logic [7:0] reg_status; // Scratch byte for software
	logic       wr_en;
	logic       rd_en;

	assign wr_en = s_chipselect & s_write;
	assign rd_en = s_chipselect & s_read;

	//////////////////////////////
	// Writes
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reg_status <= 8'h00;
			box_col    <= BOX_COL_DEFAULT;
		end else if (wr_en) begin
			case (s_address)
				ADDR_STATUS:  reg_status <= s_writedata[7:0];
				ADDR_BOX_COL: box_col    <= pixel_t'(s_writedata[23:0]);
				default:      ;
			endcase
		end
	end

	//////////////////////////////
	// Reads
	//////////////////////////////

	// Data shows one cycle after the strobe and holds until the next read
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= 32'h0;
		end else if (rd_en) begin
			case (s_address)
				ADDR_STATUS:  s_readdata <= {24'h0, reg_status};
				ADDR_ID:      s_readdata <= ID_WORD;
				ADDR_BOX_COL: s_readdata <= {8'h0, box_col};
				default:      s_readdata <= 32'h0; // Unmapped
			endcase
		end
	end

endmodule

// File: design/frame_scan.sv
module frame_scan (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               mid_valid,
	input  logic               mid_take,
	input  imgproc_pkg::beat_t mid_beat,
	output imgproc_pkg::scan_t scan
);
	import imgproc_pkg::*;

	coord_t x;
	coord_t y;
	logic   packet_video;
	logic   desc_video;

	// Descriptor with a zero low blue nibble opens a video packet
	assign desc_video = (mid_beat.pixel.blue[3:0] == 4'h0);

	//////////////////////////////
	// Coordinate counters
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x            <= '0;
			y            <= '0;
			packet_video <= 1'b0;
		end else if (mid_take) begin
			if (mid_beat.sop) begin
				x            <= '0;
				y            <= '0;
				packet_video <= desc_video; // Held until the next descriptor
			end else if (x == coord_t'(IMAGE_W - 1)) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Beat description
	//////////////////////////////

	always_comb begin
		scan.x         = x;
		scan.y         = y;
		scan.pixel     = mid_valid & ~mid_beat.sop & packet_video;
		// Descriptor beat reports the type it is about to open
		scan.video     = mid_beat.sop ? desc_video : packet_video;
		scan.frame_end = mid_valid & mid_beat.eop & scan.video;
	end

	// Line wrap keeps x inside the frame
	assert property (@(posedge clk) disable iff (!reset_n)
		x < coord_t'(IMAGE_W));

endmodule

// File: design/imgproc_pkg.sv
package imgproc_pkg;

	//////////////////////////////
	// Frame and zone geometry
	//////////////////////////////

	localparam int IMAGE_W   = 64;
	localparam int IMAGE_H   = 48;
	localparam int ZONE_COLS = 4;
	localparam int ZONE_ROWS = 4;
	localparam int ZONE_W    = IMAGE_W / ZONE_COLS; // 16 pixels
	localparam int ZONE_H    = IMAGE_H / ZONE_ROWS; // 12 lines
	localparam int NUM_ZONES = ZONE_COLS * ZONE_ROWS;
	localparam int COORD_W   = 7;

	typedef logic [COORD_W-1:0] coord_t;

	//////////////////////////////
	// Stream types
	//////////////////////////////

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	typedef struct packed {
		pixel_t pixel;
		logic   sop;
		logic   eop;
	} beat_t;

	// Position and packet state of the beat in the middle stage
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   pixel;     // Non-descriptor beat of a video packet
		logic   video;
		logic   frame_end; // Last beat of a video frame
	} scan_t;

	typedef struct packed {
		coord_t left;
		coord_t right;
		coord_t top;
		coord_t bottom;
	} box_t;

	typedef box_t [NUM_ZONES-1:0] box_set_t;

	//////////////////////////////
	// Register map
	//////////////////////////////

	localparam pixel_t BOX_COL_DEFAULT = '{red: 8'h00, green: 8'hff, blue: 8'h00};
	localparam logic [31:0] ID_WORD = 32'h1234EEE2;

	localparam logic [2:0] ADDR_STATUS  = 3'd0;
	localparam logic [2:0] ADDR_ID      = 3'd2;
	localparam logic [2:0] ADDR_BOX_COL = 3'd3;

endpackage

// File: design/imgproc_top.sv
module imgproc_top (
	input  logic               clk,
	input  logic               reset_n,

	// Register bus
	input  logic               s_chipselect,
	input  logic               s_read,
	input  logic               s_write,
	input  logic [2:0]         s_address,
	input  logic [31:0]        s_writedata,
	output logic [31:0]        s_readdata,

	// Stream sink
	input  imgproc_pkg::beat_t sink_beat,
	input  logic               sink_valid,
	output logic               sink_ready,

	// Stream source
	output imgproc_pkg::beat_t source_beat,
	output logic               source_valid,
	input  logic               source_ready,

	input  logic               mode
);
	import imgproc_pkg::*;

	beat_t    mid_beat;
	logic     mid_valid;
	logic     mid_ready;
	logic     mid_take;
	beat_t    shaded_beat;
	pixel_t   shaded_pixel;
	scan_t    scan;
	box_set_t boxes;
	pixel_t   box_col;
	logic     detect;

	assign mid_take    = mid_valid & mid_ready;
	assign shaded_beat = '{pixel: shaded_pixel, sop: mid_beat.sop, eop: mid_beat.eop};

	//////////////////////////////
	// Stream path
	//////////////////////////////

	stream_reg in_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_valid  (sink_valid),
		.in_ready  (sink_ready),
		.in_beat   (sink_beat),
		.out_valid (mid_valid),
		.out_ready (mid_ready),
		.out_beat  (mid_beat)
	);

	stream_reg out_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_valid  (mid_valid),
		.in_ready  (mid_ready),
		.in_beat   (shaded_beat),
		.out_valid (source_valid),
		.out_ready (source_ready),
		.out_beat  (source_beat)
	);

	//////////////////////////////
	// Control and datapath
	//////////////////////////////

	frame_scan scan_i (
		.clk       (clk),
		.reset_n   (reset_n),
		.mid_valid (mid_valid),
		.mid_take  (mid_take),
		.mid_beat  (mid_beat),
		.scan      (scan)
	);

	zone_tracker tracker_i (
		.clk      (clk),
		.reset_n  (reset_n),
		.mid_take (mid_take),
		.scan     (scan),
		.detect   (detect),
		.boxes    (boxes)
	);

	pixel_shader shader_i (
		.pixel_in  (mid_beat.pixel),
		.scan      (scan),
		.mode      (mode),
		.boxes     (boxes),
		.box_col   (box_col),
		.pixel_out (shaded_pixel),
		.detect    (detect)
	);

	ctrl_regs regs_i (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_writedata  (s_writedata),
		.s_readdata   (s_readdata),
		.box_col      (box_col)
	);

endmodule

// File: design/pixel_shader.sv
module pixel_shader (
	input  imgproc_pkg::pixel_t   pixel_in,
	input  imgproc_pkg::scan_t    scan,
	input  logic                  mode,
	input  imgproc_pkg::box_set_t boxes,
	input  imgproc_pkg::pixel_t   box_col,
	output imgproc_pkg::pixel_t   pixel_out,
	output logic                  detect
);
	import imgproc_pkg::*;

	localparam pixel_t WHITE = '{red: 8'hff, green: 8'hff, blue: 8'hff};

	logic [7:0] grey;
	logic       on_edge;
	pixel_t     shaded;

	// Bright in all three channels
	assign detect = pixel_in.red[7] & pixel_in.green[7] & pixel_in.blue[7];

	// Max 127 + 63 + 63, no overflow
	assign grey = {1'b0, pixel_in.green[7:1]} + {2'b0, pixel_in.red[7:2]}
		+ {2'b0, pixel_in.blue[7:2]};

	//////////////////////////////
	// Box overlay
	//////////////////////////////

	// Edges span the whole frame, not just their zone
	always_comb begin
		on_edge = 1'b0;
		for (int z = 0; z < NUM_ZONES; z++) begin
			if (scan.x == boxes[z].left || scan.x == boxes[z].right ||
				scan.y == boxes[z].top || scan.y == boxes[z].bottom) begin
				on_edge = 1'b1;
			end
		end
	end

	always_comb begin
		if (on_edge) begin
			shaded = box_col; // Overlay wins over highlight
		end else if (detect) begin
			shaded = WHITE;
		end else begin
			shaded = '{red: grey, green: grey, blue: grey};
		end
	end

	// Descriptors and non-video packets pass untouched
	assign pixel_out = (mode && scan.pixel) ? shaded : pixel_in;

endmodule

// File: design/stream_reg.sv
module stream_reg (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               in_valid,
	output logic               in_ready,
	input  imgproc_pkg::beat_t in_beat,
	output logic               out_valid,
	input  logic               out_ready,
	output imgproc_pkg::beat_t out_beat
);
	import imgproc_pkg::*;

	beat_t skid_beat;
	logic  skid_valid;
	logic  in_take;
	logic  load_out; // Output slot free or draining this cycle

	// Ready comes straight from the skid flop
	assign in_ready = ~skid_valid;
	assign in_take  = in_valid & in_ready;
	assign load_out = ~out_valid | out_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (load_out) begin
			out_valid  <= skid_valid | in_take;
			skid_valid <= 1'b0;
		end else if (in_take) begin
			skid_valid <= 1'b1; // Output stalled, park the beat
		end
	end

	always_ff @(posedge clk) begin
		if (load_out) begin
			out_beat <= skid_valid ? skid_beat : in_beat; // Skid entry is older
		end
		if (in_take && !load_out) begin
			skid_beat <= in_beat;
		end
	end

	// A stalled beat must hold until it is taken
	assert property (@(posedge clk) disable iff (!reset_n)
		out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

// File: design/zone_tracker.sv
module zone_tracker (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  mid_take,
	input  imgproc_pkg::scan_t    scan,
	input  logic                  detect,
	output imgproc_pkg::box_set_t boxes
);
	import imgproc_pkg::*;

	localparam int ZONE_IDX_W = $clog2(NUM_ZONES);

	// Empty bounds, inverted so the first hit overwrites them
	localparam box_t ACC_INIT = '{
		left:   coord_t'(IMAGE_W - 1),
		right:  coord_t'(0),
		top:    coord_t'(IMAGE_H - 1),
		bottom: coord_t'(0)
	};

	box_set_t              acc;      // left/right/top/bottom hold min x, max x, min y, max y
	box_set_t              acc_next;
	coord_t                zone_col;
	coord_t                zone_row;
	logic [ZONE_IDX_W-1:0] zone;
	logic                  preset;
	logic                  hit;

	assign zone_col = coord_t'(scan.x / ZONE_W);
	assign zone_row = coord_t'(scan.y / ZONE_H);
	assign zone     = ZONE_IDX_W'(zone_row * ZONE_COLS + zone_col);

	// Video descriptor opens a fresh frame
	assign preset = mid_take & scan.video & ~scan.pixel;
	assign hit    = mid_take & scan.pixel & detect & (scan.y < coord_t'(IMAGE_H));

	//////////////////////////////
	// Bound accumulators
	//////////////////////////////

	always_comb begin
		acc_next = acc;
		if (preset) begin
			for (int z = 0; z < NUM_ZONES; z++) begin
				acc_next[z] = ACC_INIT;
			end
		end else if (hit) begin
			if (scan.x < acc[zone].left)   acc_next[zone].left   = scan.x;
			if (scan.x > acc[zone].right)  acc_next[zone].right  = scan.x;
			if (scan.y < acc[zone].top)    acc_next[zone].top    = scan.y;
			if (scan.y > acc[zone].bottom) acc_next[zone].bottom = scan.y;
		end
	end

	always_ff @(posedge clk) begin
		acc <= acc_next;
	end

	//////////////////////////////
	// Box latch
	//////////////////////////////

	// Latch includes the eop pixel's own update
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			boxes <= '0;
		end else if (mid_take && scan.frame_end) begin
			boxes <= acc_next;
		end
	end

	for (genvar z = 0; z < NUM_ZONES; z++) begin : g_box_chk
		assert property (@(posedge clk) disable iff (!reset_n)
			mid_take && scan.frame_end |=>
				boxes[z].left < coord_t'(IMAGE_W) && boxes[z].right < coord_t'(IMAGE_W) &&
				boxes[z].top < coord_t'(IMAGE_H) && boxes[z].bottom < coord_t'(IMAGE_H));
	end

endmodule

// File: imgproc.f
+incdir+verif
design/imgproc_pkg.sv
design/stream_reg.sv
design/frame_scan.sv
design/zone_tracker.sv
design/pixel_shader.sv
design/ctrl_regs.sv
design/imgproc_top.sv
verif/imgproc_tb.sv

// File: verif/imgproc_model.svh
`ifndef IMGPROC_MODEL_SVH
`define IMGPROC_MODEL_SVH

beat_t    expect_q[$];  // Source beats in the order they must leave
box_set_t model_boxes;  // Boxes drawn on the current frame
box_set_t model_acc;    // left/right/top/bottom hold min x, max x, min y, max y
pixel_t   model_col;
logic     model_video;
int       model_x;
int       model_y;

function automatic void reset_model();
	model_boxes = '0; // No frame seen yet
	model_acc   = '0;
	model_col   = BOX_COL_DEFAULT;
	model_video = 1'b0;
	model_x     = 0;
	model_y     = 0;
	expect_q.delete();
endfunction

function automatic logic is_bright(input pixel_t p);
	return p.red[7] && p.green[7] && p.blue[7];
endfunction

// Any latched edge of any zone, anywhere in the frame
function automatic logic on_box_edge(input int x, input int y);
	for (int z = 0; z < NUM_ZONES; z++) begin
		if (x == int'(model_boxes[z].left) || x == int'(model_boxes[z].right)) return 1'b1;
		if (y == int'(model_boxes[z].top) || y == int'(model_boxes[z].bottom)) return 1'b1;
	end
	return 1'b0;
endfunction

function automatic pixel_t shade_pixel(input pixel_t p, input int x, input int y);
	int grey;
	grey = int'(p.green) / 2 + int'(p.red) / 4 + int'(p.blue) / 4;
	if (on_box_edge(x, y)) return model_col;
	if (is_bright(p)) return '{red: 8'hff, green: 8'hff, blue: 8'hff};
	return '{red: 8'(grey), green: 8'(grey), blue: 8'(grey)};
endfunction

function automatic void record_hit(input int x, input int y);
	int z;
	z = (y / ZONE_H) * ZONE_COLS + x / ZONE_W;
	if (x < int'(model_acc[z].left))   model_acc[z].left   = coord_t'(x);
	if (x > int'(model_acc[z].right))  model_acc[z].right  = coord_t'(x);
	if (y < int'(model_acc[z].top))    model_acc[z].top    = coord_t'(y);
	if (y > int'(model_acc[z].bottom)) model_acc[z].bottom = coord_t'(y);
endfunction

// Beats reach the model in sink order, the same order the middle stage sees
function automatic void predict_beat(input beat_t b, input logic mode_now);
	beat_t exp_b;
	exp_b = b;
	if (b.sop) begin
		model_video = (b.pixel.blue[3:0] == 4'h0);
		model_x     = 0;
		model_y     = 0;
		if (model_video) begin
			for (int z = 0; z < NUM_ZONES; z++) begin
				model_acc[z] = '{left: coord_t'(IMAGE_W - 1), right: '0,
					top: coord_t'(IMAGE_H - 1), bottom: '0};
			end
		end
	end else begin
		if (model_video) begin
			if (mode_now) exp_b.pixel = shade_pixel(b.pixel, model_x, model_y);
			if (is_bright(b.pixel)) record_hit(model_x, model_y);
			if (b.eop) model_boxes = model_acc; // Later beats see the new boxes
		end
		model_x++;
		if (model_x == IMAGE_W) begin
			model_x = 0;
			model_y++;
		end
	end
	expect_q.push_back(exp_b);
endfunction

`endif

// File: verif/imgproc_tb.sv
module imgproc_tb;
	import imgproc_pkg::*;

	localparam int BEAT_TIMEOUT  = 2000;
	localparam int DRAIN_TIMEOUT = 5000;
	localparam int NUM_PACKETS   = 10;

	logic        clk;
	logic        reset_n;
	logic        s_chipselect;
	logic        s_read;
	logic        s_write;
	logic [2:0]  s_address;
	logic [31:0] s_writedata;
	logic [31:0] s_readdata;
	beat_t       sink_beat;
	logic        sink_valid;
	logic        sink_ready;
	beat_t       source_beat;
	logic        source_valid;
	logic        source_ready;
	logic        mode;
	logic [31:0] stim_state;  // LFSR for stimulus
	logic [31:0] stall_state; // LFSR for source back-pressure
	logic        stalls_on;

	`include "imgproc_model.svh"

	imgproc_top imgproc_top_i (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_writedata  (s_writedata),
		.s_readdata   (s_readdata),
		.sink_beat    (sink_beat),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.source_beat  (source_beat),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.mode         (mode)
	);

	always #4 clk = ~clk;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits  = {bits[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
		end
		return bits;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Error at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	//////////////////////////////
	// Source side
	//////////////////////////////

	always @(posedge clk) begin
		if (reset_n && source_valid && source_ready) begin
			if (expect_q.size() == 0) begin
				stop_on_error("A beat left the source while none was expected");
			end else begin
				check_value("source beat", 32'(source_beat), 32'(expect_q[0]));
				void'(expect_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		if (stalls_on) source_ready <= (take_bits(stall_state, 2) != 0); // Ready 3 of 4
		else source_ready <= 1'b1;
	end

	//////////////////////////////
	// Sink side
	//////////////////////////////

	task automatic idle_cycles(input int n);
		sink_valid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	task automatic send_beat(input beat_t b, input logic mode_now);
		int waited;
		int gap;
		gap = (take_bits(stim_state, 2) == 0) ? int'(take_bits(stim_state, 2)) + 1 : 0;
		if (gap > 0) idle_cycles(gap);
		sink_beat  <= b;
		sink_valid <= 1'b1;
		predict_beat(b, mode_now);
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > BEAT_TIMEOUT) stop_on_error("The sink did not accept a beat in time");
		end while (!sink_ready);
	endtask

	// Density sets how many pixels of a frame are bright
	function automatic pixel_t random_pixel(input int density);
		pixel_t p;
		p = pixel_t'(take_bits(stim_state, 24));
		if (int'(take_bits(stim_state, 6)) < density) begin
			p.red[7]   = 1'b1;
			p.green[7] = 1'b1;
			p.blue[7]  = 1'b1;
		end else begin
			p.red[7] = 1'b0;
		end
		return p;
	endfunction

	task automatic drive_packet(input logic video, input logic mode_now);
		beat_t b;
		int    len;
		int    density;
		case (take_bits(stim_state, 2))
			0:       density = 0;  // Every zone empty
			1:       density = 1;
			2:       density = 3;
			default: density = 12;
		endcase
		b       = '0;
		b.sop   = 1'b1;
		b.pixel = pixel_t'(take_bits(stim_state, 24));
		if (video) begin
			b.pixel.blue[3:0] = 4'h0;
			len = IMAGE_W * IMAGE_H;
		end else begin
			if (b.pixel.blue[3:0] == 4'h0) b.pixel.blue[3:0] = 4'h9;
			len = 4 + int'(take_bits(stim_state, 4));
		end
		send_beat(b, mode_now);
		for (int i = 0; i < len; i++) begin
			b.sop   = 1'b0;
			b.eop   = (i == len - 1);
			b.pixel = random_pixel(density);
			send_beat(b, mode_now);
		end
		sink_valid <= 1'b0;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (expect_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > DRAIN_TIMEOUT) stop_on_error("The stream did not drain in time");
		end
	endtask

	//////////////////////////////
	// Register bus
	//////////////////////////////

	task automatic write_register(input logic [2:0] addr, input logic [31:0] data);
		s_chipselect <= 1'b1;
		s_write      <= 1'b1;
		s_address    <= addr;
		s_writedata  <= data;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_write      <= 1'b0;
	endtask

	task automatic read_register(input logic [2:0] addr, output logic [31:0] data);
		s_chipselect <= 1'b1;
		s_read       <= 1'b1;
		s_address    <= addr;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_read       <= 1'b0;
		@(posedge clk); // Read data one cycle after the strobe
		data = s_readdata;
	endtask

	task automatic test_registers();
		logic [31:0] value;
		read_register(ADDR_ID, value);
		check_value("ID register", value, ID_WORD);
		read_register(ADDR_STATUS, value);
		check_value("status after reset", value, 32'h0);
		read_register(ADDR_BOX_COL, value);
		check_value("box colour after reset", value, {8'h0, BOX_COL_DEFAULT});
		write_register(ADDR_STATUS, 32'hdead_bea5);
		read_register(ADDR_STATUS, value);
		check_value("status byte", value, 32'h0000_00a5);
		for (int a = 0; a < 8; a++) begin
			if (a != ADDR_STATUS && a != ADDR_ID && a != ADDR_BOX_COL) begin
				read_register(3'(a), value);
				check_value("unmapped register", value, 32'h0);
			end
		end
	endtask

	task automatic change_box_colour();
		logic [31:0] value;
		pixel_t      col;
		col = pixel_t'(take_bits(stim_state, 24));
		write_register(ADDR_BOX_COL, {8'hff, col}); // Top byte is ignored
		model_col = col;
		read_register(ADDR_BOX_COL, value);
		check_value("box colour register", value, {8'h0, col});
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		logic video;
		logic mode_now;
		int   waited;
		clk          = 1'b0;
		reset_n      = 1'b0;
		s_chipselect = 1'b0;
		s_read       = 1'b0;
		s_write      = 1'b0;
		s_address    = '0;
		s_writedata  = '0;
		sink_beat    = '0;
		sink_valid   = 1'b0;
		source_ready = 1'b0;
		mode         = 1'b0;
		stalls_on    = 1'b0;
		stim_state   = 32'h6af1_8120;
		stall_state  = 32'h6af1_8120;
		reset_model();
		repeat (4) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		check_value("source_valid after reset", 32'(source_valid), 32'h0);
		check_value("sink_ready after reset", 32'(sink_ready), 32'h1);
		test_registers();
		for (int p = 0; p < NUM_PACKETS; p++) begin
			wait_drained(); // Mode and colour only change on an idle stream
			if (p < 2) begin
				video    = 1'b1; // Reset boxes first and real ones after
				mode_now = 1'b1;
			end else if (p == 2) begin
				video    = 1'b0;
				mode_now = 1'b1;
			end else if (p == 3) begin
				video    = 1'b1; // Boxes of packet 1 in the new colour
				mode_now = 1'b1;
			end else begin
				video    = (take_bits(stim_state, 2) != 0);
				mode_now = (take_bits(stim_state, 1) != 0);
			end
			if (p == 3 || p == 6) change_box_colour();
			mode      <= mode_now;
			stalls_on <= (take_bits(stim_state, 1) != 0);
			drive_packet(video, mode_now);
		end
		waited = 0;
		while (expect_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (expect_q.size() != 0) begin
			stop_on_error("Expected beats were still pending after the last packet");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule
